//--- design/simd_alu_macros.svh
// sizing constants for the packed-SIMD ALU
// lane geometry is fixed at four 8-bit lanes, queue depths must be 2 or more
`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath geometry
////////////////////////////////////////////////////////////////////////////

// full operand and result width
`define SIMD_XLEN 32
// narrowest lane, VEC8 mode
`define SIMD_LANE_W 8
// narrow lanes per word
`define SIMD_NUM_LANES 4

////////////////////////////////////////////////////////////////////////////
// queues and credits
////////////////////////////////////////////////////////////////////////////

// input queue, also the upstream credit count after reset
`define SIMD_IN_DEPTH 4
// output queue
`define SIMD_OUT_DEPTH 4
// downstream credits held after reset
`define SIMD_OUT_CREDITS 2

`endif

//--- design/simd_lane_pkg.sv
// datapath word and lane types shared by both pipeline stages
// the lane view always splits a word into byte lanes, wider modes group them
`include "simd_alu_macros.svh"

package simd_lane_pkg;

  // one operand or result word
  typedef logic [`SIMD_XLEN-1:0] word_t;

  // same word seen as byte lanes, index 0 is the least significant byte
  typedef logic [`SIMD_NUM_LANES-1:0][`SIMD_LANE_W-1:0] lane_view_t;

  // one flag per byte lane
  // in VEC16 and VEC32 the flag is repeated over all bytes of the wide lane
  typedef logic [`SIMD_NUM_LANES-1:0] lane_mask_t;

endpackage

//--- design/simd_op_pkg.sv
// operation codes, vector modes and the structs moved between the ALU blocks
// RELU and MAC take their lane width from the vector mode
`include "simd_alu_macros.svh"

package simd_op_pkg;

  import simd_lane_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ADD, SUB,
    AND, OR, XOR,
    EQ, NE, LT, LTU, GE, GEU,
    MIN, MINU, MAX, MAXU,
    RELU,
    MAC
  } alu_op_e;

  // same codes as the core ALU, 2'b01 is unused and falls back to 32-bit lanes
  typedef enum logic [1:0] {
    VEC32 = 2'b00,
    VEC16 = 2'b10,
    VEC8  = 2'b11
  } vec_mode_e;

  // four 17-bit byte products or two 33-bit halfword products
  typedef logic [`SIMD_NUM_LANES*(2*`SIMD_LANE_W+1)-1:0] prod_field_t;

  ////////////////////////////////////////////////////////////////////////////
  // payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e   op;
    vec_mode_e mode;
    word_t     a;
    word_t     b;
    // accumulator, MAC only
    word_t     c;
  } alu_req_t;

  typedef struct packed {
    word_t result;
  } alu_rsp_t;

  // handed from stage 1 to stage 2
  typedef struct packed {
    logic        is_mac;
    vec_mode_e   mode;
    word_t       c;
    // finished result for everything but MAC
    word_t       result;
    // signed lane products, VEC32 keeps the low 32 bits of a*b here
    prod_field_t prod;
  } stage1_t;

endpackage

//--- design/credit_fifo.sv
// circular FIFO for any packed payload that never reads while empty or writes while full
// DEPTH must be 2 or more and head_o is only meaningful while empty_o is low
module credit_fifo #(
  parameter type         T     = logic [31:0],
  parameter int unsigned DEPTH = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  T                             push_data_i,
  input  logic                         pop_i,
  output T                             head_o,
  output logic                         empty_o,
  output logic                         full_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o,
  output logic                         credit_o
);

  localparam int unsigned PW = $clog2(DEPTH);

  T               mem [DEPTH];
  logic [PW-1:0]  rd_ptr;
  logic [PW-1:0]  wr_ptr;

  // pointer advance with wrap for any depth
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head_o  = mem[rd_ptr];
  assign empty_o = (count_o == '0);
  assign full_o  = (count_o == DEPTH);

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count_o  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push_i, pop_i})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: ;
      endcase
      // freed slot goes back to the sender one cycle after the pop
      credit_o <= pop_i;
    end
  end

  // the sender's credit count must keep it from overrunning the queue
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o)
    else $error("push into full queue");

  // the consumer must only pop what is there
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o)
    else $error("pop from empty queue");

endmodule

//--- design/flow_ctrl.sv
// issue and output control where stages never stall so issue reserves queue space
// a receiver must never return more credits than it was given
`include "simd_alu_macros.svh"

module flow_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   in_empty_i,
  input  logic [$clog2(`SIMD_OUT_DEPTH+1)-1:0]   out_count_i,
  input  logic                                   out_empty_i,
  input  logic                                   s2_valid_i,
  input  logic                                   rsp_credit_i,
  output logic                                   issue_o,
  output logic                                   out_pop_o
);

  localparam int unsigned CRW = $clog2(`SIMD_OUT_CREDITS + 1);

  // items between issue and the write into the output queue (0 to 2)
  logic [1:0]     inflight;
  // downstream credits on hand
  logic [CRW-1:0] credits;

  ////////////////////////////////////////////////////////////////////////////
  // issue side
  ////////////////////////////////////////////////////////////////////////////

  // space already taken plus space promised must leave room for one more
  assign issue_o = !in_empty_i && ((out_count_i + inflight) < `SIMD_OUT_DEPTH);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight <= '0;
    end else begin
      case ({issue_o, s2_valid_i})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////////////////////

  // a result leaves only when the receiver has room for it
  assign out_pop_o = !out_empty_i && (credits != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits <= CRW'(`SIMD_OUT_CREDITS);
    end else begin
      case ({rsp_credit_i, out_pop_o})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
    end
  end

  // receiver handed back more credits than results it got
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits <= `SIMD_OUT_CREDITS)
    else $error("downstream credit overflow");

  // every in-flight item already owns a slot in the output queue
  a_reserve_fits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_count_i + inflight) <= `SIMD_OUT_DEPTH)
    else $error("output queue overbooked by in-flight items");

endmodule

//--- design/lane_arith_stage.sv
// stage 1, all lane arithmetic and logic, registered into one stage1_t
// MAC only forms the lane products here, stage 2 does the sum
`include "simd_alu_macros.svh"

module lane_arith_stage
  import simd_lane_pkg::*, simd_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  alu_req_t req_i,
  output logic     valid_o,
  output stage1_t  s1_o
);

  localparam int LW  = `SIMD_LANE_W;
  localparam int NL  = `SIMD_NUM_LANES;
  localparam int AW  = NL * (LW + 1);
  localparam int HW  = 2 * LW;
  localparam int P8  = 2 * LW + 1;
  localparam int P16 = 2 * HW + 1;

  lane_view_t  a_v;
  lane_view_t  b_v;
  lane_view_t  res_v;
  // byte starts a lane / byte holds a lane's sign bit
  lane_mask_t  lane_lo;
  lane_mask_t  lane_hi;

  assign a_v = req_i.a;
  assign b_v = req_i.b;

  always_comb begin
    case (req_i.mode)
      VEC8: begin
        lane_lo = 4'b1111;
        lane_hi = 4'b1111;
      end
      VEC16: begin
        lane_lo = 4'b0101;
        lane_hi = 4'b1010;
      end
      default: begin
        lane_lo = 4'b0001;
        lane_hi = 4'b1000;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // partitioned adder
  ////////////////////////////////////////////////////////////////////////////

  logic          sub;
  word_t         b_op;
  logic [AW-1:0] add_a;
  logic [AW-1:0] add_b;
  logic [AW-1:0] add_sum;
  word_t         add_res;

  assign sub  = (req_i.op == SUB);
  // a - b as a + ~b + 1, the +1 enters at each lane start
  assign b_op = sub ? ~req_i.b : req_i.b;

  // one spare bit below every byte
  // inside a lane it is 1+0 and passes the carry on
  // at a lane start it is 0+0 (add, carry killed) or 1+1 (sub, carry forced)
  always_comb begin
    for (int i = 0; i < NL; i++) begin
      add_a[(LW+1)*i]          = lane_lo[i] ? sub : 1'b1;
      add_b[(LW+1)*i]          = lane_lo[i] ? sub : 1'b0;
      add_a[(LW+1)*i+1 +: LW]  = a_v[i];
      add_b[(LW+1)*i+1 +: LW]  = b_op[LW*i +: LW];
    end
  end

  assign add_sum = add_a + add_b;

  always_comb begin
    for (int i = 0; i < NL; i++) begin
      add_res[LW*i +: LW] = add_sum[(LW+1)*i+1 +: LW];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparison, min/max
  ////////////////////////////////////////////////////////////////////////////

  logic       is_signed;
  logic       do_min;
  lane_mask_t eq_b;
  lane_mask_t gt_b;
  lane_mask_t eq_m;
  lane_mask_t gt_m;
  lane_mask_t cmp_m;
  lane_mask_t sel_a;

  always_comb begin
    case (req_i.op)
      LT, GE, MIN, MAX: is_signed = 1'b1;
      default:          is_signed = 1'b0;
    endcase
  end

  assign do_min = (req_i.op == MIN) || (req_i.op == MINU);

  // byte compares, only the top byte of a lane sees the sign
  always_comb begin
    for (int i = 0; i < NL; i++) begin
      eq_b[i] = (a_v[i] == b_v[i]);
      gt_b[i] = $signed({is_signed & lane_hi[i] & a_v[i][LW-1], a_v[i]}) >
                $signed({is_signed & lane_hi[i] & b_v[i][LW-1], b_v[i]});
    end
  end

  // merge byte results into wide lanes, upper byte decides unless equal
  always_comb begin
    eq_m = eq_b;
    gt_m = gt_b;
    case (req_i.mode)
      VEC16: begin
        eq_m[1:0] = {2{&eq_b[1:0]}};
        eq_m[3:2] = {2{&eq_b[3:2]}};
        gt_m[1:0] = {2{gt_b[1] | (eq_b[1] & gt_b[0])}};
        gt_m[3:2] = {2{gt_b[3] | (eq_b[3] & gt_b[2])}};
      end
      VEC8: ;
      default: begin
        eq_m = {NL{&eq_b}};
        gt_m = {NL{gt_b[3] | (eq_b[3] & (gt_b[2] | (eq_b[2] & (gt_b[1] |
                   (eq_b[1] & gt_b[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      EQ:      cmp_m = eq_m;
      NE:      cmp_m = ~eq_m;
      LT, LTU: cmp_m = ~(gt_m | eq_m);
      default: cmp_m = gt_m | eq_m;
    endcase
  end

  // max keeps a when a > b, min keeps a otherwise
  assign sel_a = gt_m ^ {NL{do_min}};

  ////////////////////////////////////////////////////////////////////////////
  // relu and lane products
  ////////////////////////////////////////////////////////////////////////////

  lane_mask_t  neg_m;
  prod_field_t prod;

  // lane sign spread over every byte of the lane
  always_comb begin
    case (req_i.mode)
      VEC8:    neg_m = {a_v[3][LW-1], a_v[2][LW-1], a_v[1][LW-1], a_v[0][LW-1]};
      VEC16:   neg_m = {{2{a_v[3][LW-1]}}, {2{a_v[1][LW-1]}}};
      default: neg_m = {NL{a_v[3][LW-1]}};
    endcase
  end

  // signed products, sign extended to the field width by the signed context
  always_comb begin
    prod = '0;
    case (req_i.mode)
      VEC8: begin
        for (int i = 0; i < NL; i++) begin
          prod[P8*i +: P8] = $signed(a_v[i]) * $signed(b_v[i]);
        end
      end
      VEC16: begin
        for (int i = 0; i < NL / 2; i++) begin
          prod[P16*i +: P16] = $signed(req_i.a[HW*i +: HW]) * $signed(req_i.b[HW*i +: HW]);
        end
      end
      // low word is the same for signed and unsigned
      default: prod[`SIMD_XLEN-1:0] = req_i.a * req_i.b;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result select and pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    res_v = '0;
    case (req_i.op)
      ADD, SUB: res_v = add_res;
      AND:      res_v = req_i.a & req_i.b;
      OR:       res_v = req_i.a | req_i.b;
      XOR:      res_v = req_i.a ^ req_i.b;
      EQ, NE, LT, LTU, GE, GEU: begin
        for (int i = 0; i < NL; i++) begin
          res_v[i] = {LW{cmp_m[i]}};
        end
      end
      MIN, MINU, MAX, MAXU: begin
        for (int i = 0; i < NL; i++) begin
          res_v[i] = sel_a[i] ? a_v[i] : b_v[i];
        end
      end
      RELU: begin
        for (int i = 0; i < NL; i++) begin
          res_v[i] = neg_m[i] ? '0 : a_v[i];
        end
      end
      // MAC result is built in stage 2
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_o.is_mac <= (req_i.op == MAC);
      s1_o.mode   <= req_i.mode;
      s1_o.c      <= req_i.c;
      s1_o.result <= res_v;
      s1_o.prod   <= prod;
    end
  end

endmodule

//--- design/dot_mac_stage.sv
// stage 2, dot-product accumulate for MAC, plain register for all else
// the sum wraps modulo 2^32 with no saturation
`include "simd_alu_macros.svh"

module dot_mac_stage
  import simd_lane_pkg::*, simd_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  stage1_t  s1_i,
  output logic     valid_o,
  output alu_rsp_t rsp_o
);

  // product field slices, 17 bits per byte lane and 33 per halfword lane
  localparam int P8  = 2 * `SIMD_LANE_W + 1;
  localparam int P16 = 4 * `SIMD_LANE_W + 1;

  word_t dot_sum;

  // c plus every lane product
  always_comb begin
    dot_sum = s1_i.c;
    case (s1_i.mode)
      VEC8: begin
        for (int i = 0; i < `SIMD_NUM_LANES; i++) begin
          dot_sum = dot_sum + {{(`SIMD_XLEN - P8){s1_i.prod[P8*i+P8-1]}},
                               s1_i.prod[P8*i +: P8]};
        end
      end
      VEC16: begin
        // low word of a 33-bit product already is its value mod 2^32
        for (int i = 0; i < `SIMD_NUM_LANES / 2; i++) begin
          dot_sum = dot_sum + s1_i.prod[P16*i +: `SIMD_XLEN];
        end
      end
      default: dot_sum = dot_sum + s1_i.prod[`SIMD_XLEN-1:0];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_o.result <= s1_i.is_mac ? dot_sum : s1_i.result;
    end
  end

endmodule

//--- design/simd_alu_top.sv
// packed-SIMD ALU with credit flow control on both sides
// upstream starts with SIMD_IN_DEPTH credits, results leave only against credits
`include "simd_alu_macros.svh"

module simd_alu_top
  import simd_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  alu_req_t req_i,
  output logic     req_credit_o,
  output logic     rsp_valid_o,
  output alu_rsp_t rsp_o,
  input  logic     rsp_credit_i
);

  alu_req_t                               in_head;
  logic                                   in_empty;
  logic                                   issue;
  logic                                   s1_valid;
  stage1_t                                s1;
  logic                                   s2_valid;
  alu_rsp_t                               s2_rsp;
  alu_rsp_t                               out_head;
  logic                                   out_empty;
  logic                                   out_pop;
  logic [$clog2(`SIMD_OUT_DEPTH+1)-1:0]   out_count;

  ////////////////////////////////////////////////////////////////////////////
  // input queue and issue
  ////////////////////////////////////////////////////////////////////////////

  // its pop pulse is the upstream credit return
  credit_fifo #(.T(alu_req_t), .DEPTH(`SIMD_IN_DEPTH)) u_in_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (req_valid_i),
    .push_data_i (req_i),
    .pop_i       (issue),
    .head_o      (in_head),
    .empty_o     (in_empty),
    .full_o      (),
    .count_o     (),
    .credit_o    (req_credit_o)
  );

  flow_ctrl u_flow (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_empty_i   (in_empty),
    .out_count_i  (out_count),
    .out_empty_i  (out_empty),
    .s2_valid_i   (s2_valid),
    .rsp_credit_i (rsp_credit_i),
    .issue_o      (issue),
    .out_pop_o    (out_pop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath, two stages that never stall
  ////////////////////////////////////////////////////////////////////////////

  lane_arith_stage u_stage1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (issue),
    .req_i   (in_head),
    .valid_o (s1_valid),
    .s1_o    (s1)
  );

  dot_mac_stage u_stage2 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s1_valid),
    .s1_i    (s1),
    .valid_o (s2_valid),
    .rsp_o   (s2_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output queue and response register
  ////////////////////////////////////////////////////////////////////////////

  // registered pop pulse is exactly the response valid
  credit_fifo #(.T(alu_rsp_t), .DEPTH(`SIMD_OUT_DEPTH)) u_out_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (s2_valid),
    .push_data_i (s2_rsp),
    .pop_i       (out_pop),
    .head_o      (out_head),
    .empty_o     (out_empty),
    .full_o      (),
    .count_o     (out_count),
    .credit_o    (rsp_valid_o)
  );

  // result captured alongside the pop so it lines up with rsp_valid_o
  always_ff @(posedge clk_i) begin
    if (out_pop) begin
      rsp_o <= out_head;
    end
  end

endmodule

//--- sim/tb_clock_gen.sv
// free-running testbench clock, period 20, reset low for the first 4 rising edges
// reset is let go on a falling edge so it never meets the sampling edge
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- sim/simd_alu_tb.sv
// directed tests for the SIMD ALU with every result checked against a lane-wise model
// inputs change on the falling edge and DUT outputs are sampled on the rising edge
`include "simd_alu_macros.svh"

module simd_alu_tb
  import simd_lane_pkg::*, simd_op_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int ARITH_REQS      = 27;
  localparam int CMP_REQS        = 30;
  localparam int RELU_MAC_REQS   = 12;
  localparam int HOLD_REQS       = 10;
  localparam int BURST_REQS      = `SIMD_IN_DEPTH;
  localparam int TOTAL_REQS      = ARITH_REQS + CMP_REQS + RELU_MAC_REQS + HOLD_REQS + BURST_REQS;
  // 40 cycles per request plus a margin for reset and the back-pressure window
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_REQS + 300;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  alu_req_t  req;
  logic      req_credit;
  logic      rsp_valid;
  alu_rsp_t  rsp;
  logic      rsp_credit;
  logic      hold_credits;
  vec_mode_e modes [3];

  // expected and received results, both in request order
  word_t exp_q [$];
  word_t got_q [$];
  int    sent_total    = 0;
  int    credits_back  = 0;
  int    rsp_total     = 0;
  int    credits_given = 0;
  int    test_errors   = 0;
  int    total_errors  = 0;
  int    tests_run     = 0;
  int    checks        = 0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  simd_alu_top dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .rsp_credit_i (rsp_credit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // monitors and receiver
  ////////////////////////////////////////////////////////////////////////////

  // results and upstream credit pulses
  always @(posedge clk) begin
    if (rsp_valid) begin
      got_q.push_back(rsp.result);
      rsp_total++;
    end
    if (req_credit) begin
      credits_back++;
    end
  end

  // one credit back per received result and at most one per cycle while not held
  always @(negedge clk) begin
    if (!hold_credits && (credits_given < rsp_total)) begin
      rsp_credit = 1'b1;
      credits_given++;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped delivering results",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // each lane taken as w-bit unsigned and signed numbers
  task automatic ref_model(input alu_req_t r, output word_t res);
    int     w;
    longint mask;
    longint sign;
    longint ua;
    longint ub;
    longint sa;
    longint sb;
    longint lane;
    longint acc;
    longint word;
    case (r.mode)
      VEC8:    w = 8;
      VEC16:   w = 16;
      default: w = 32;
    endcase
    mask = (longint'(1) << w) - 1;
    sign = longint'(1) << (w - 1);
    acc  = 0;
    word = 0;
    for (int i = 0; i < 32 / w; i++) begin
      ua = longint'(r.a >> (i * w)) & mask;
      ub = longint'(r.b >> (i * w)) & mask;
      sa = (ua ^ sign) - sign;
      sb = (ub ^ sign) - sign;
      lane = 0;
      case (r.op)
        ADD:     lane = ua + ub;
        SUB:     lane = ua - ub;
        AND:     lane = ua & ub;
        OR:      lane = ua | ub;
        XOR:     lane = ua ^ ub;
        EQ:      lane = (ua == ub) ? mask : 0;
        NE:      lane = (ua != ub) ? mask : 0;
        LT:      lane = (sa < sb) ? mask : 0;
        LTU:     lane = (ua < ub) ? mask : 0;
        GE:      lane = (sa >= sb) ? mask : 0;
        GEU:     lane = (ua >= ub) ? mask : 0;
        MIN:     lane = (sa < sb) ? ua : ub;
        MINU:    lane = (ua < ub) ? ua : ub;
        MAX:     lane = (sa > sb) ? ua : ub;
        MAXU:    lane = (ua > ub) ? ua : ub;
        RELU:    lane = (sa < 0) ? 0 : ua;
        MAC:     acc = acc + sa * sb;
        default: lane = 0;
      endcase
      word = word | ((lane & mask) << (i * w));
    end
    res = (r.op == MAC) ? word_t'(longint'(r.c) + acc) : word_t'(word);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // driving and checking helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int up_credits();
    return `SIMD_IN_DEPTH - sent_total + credits_back;
  endfunction

  // random word with about half of its bytes copied from a so that lanes tie often
  function automatic word_t mix_bytes(input word_t a);
    word_t b;
    b = $urandom;
    for (int i = 0; i < `SIMD_NUM_LANES; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        b[`SIMD_LANE_W*i +: `SIMD_LANE_W] = a[`SIMD_LANE_W*i +: `SIMD_LANE_W];
      end
    end
    return b;
  endfunction

  // one beat on the next falling edge with a credit and valid left high
  task automatic send_req(input alu_op_e op, input vec_mode_e mode,
                          input word_t a, input word_t b, input word_t c);
    alu_req_t r;
    word_t    exp_word;
    r.op   = op;
    r.mode = mode;
    r.a    = a;
    r.b    = b;
    r.c    = c;
    ref_model(r, exp_word);
    exp_q.push_back(exp_word);
    @(negedge clk);
    while (up_credits() == 0) begin
      req_valid = 1'b0;
      @(negedge clk);
    end
    req_valid = 1'b1;
    req       = r;
    sent_total++;
  endtask

  task automatic end_burst();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic check_word(input string name, input word_t exp_word, input word_t got_word);
    checks++;
    assert (got_word == exp_word) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp_word, got_word);
      test_errors++;
    end
  endtask

  // waits for every outstanding result, then compares them in order
  task automatic drain_and_check(input string name);
    while (got_q.size() < exp_q.size()) begin
      @(negedge clk);
    end
    while (exp_q.size() > 0) begin
      check_word(name, exp_q.pop_front(), got_q.pop_front());
    end
  endtask

  // all received results have had their credit returned
  task automatic settle_credits();
    while (credits_given != rsp_total) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    $display("%-16s done, %0d error(s)", name, test_errors);
    total_errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    repeat (10) @(negedge clk);
    checks++;
    assert (rsp_total == 0 && credits_back == 0 && !rsp_valid && !req_credit) else begin
      $display("reset_state: response valid or upstream credit pulsed with no request sent");
      test_errors++;
    end
    finish_test("reset_state");
  endtask

  // carry and borrow across every lane edge first and random operands after
  task automatic test_lane_arith();
    for (int m = 0; m < 3; m++) begin
      send_req(ADD, modes[m], 32'hffff_ffff, 32'h0000_0001, '0);
      send_req(SUB, modes[m], 32'h0000_0000, 32'h0000_0001, '0);
      for (int j = 0; j < 2; j++) begin
        send_req(ADD, modes[m], $urandom, $urandom, '0);
        send_req(SUB, modes[m], $urandom, $urandom, '0);
      end
      send_req(AND, modes[m], $urandom, $urandom, '0);
      send_req(OR, modes[m], $urandom, $urandom, '0);
      send_req(XOR, modes[m], $urandom, $urandom, '0);
    end
    end_burst();
    drain_and_check("lane_arith");
    finish_test("lane_arith");
  endtask

  task automatic test_compare();
    alu_op_e cmp_ops [10];
    word_t   a;
    cmp_ops = '{EQ, NE, LT, LTU, GE, GEU, MIN, MINU, MAX, MAXU};
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 10; k++) begin
        a = $urandom;
        send_req(cmp_ops[k], modes[m], a, mix_bytes(a), '0);
      end
    end
    end_burst();
    drain_and_check("compare_minmax");
    finish_test("compare_minmax");
  endtask

  task automatic test_relu_mac();
    for (int m = 0; m < 3; m++) begin
      for (int j = 0; j < 2; j++) begin
        send_req(RELU, modes[m], $urandom, '0, '0);
        send_req(MAC, modes[m], $urandom, $urandom, $urandom);
      end
    end
    end_burst();
    drain_and_check("relu_mac");
    finish_test("relu_mac");
  endtask

  // only the credits held after reset may let results out while credits are withheld
  task automatic test_back_pressure();
    int base;
    settle_credits();
    hold_credits = 1'b1;
    base = rsp_total;
    for (int i = 0; i < HOLD_REQS; i++) begin
      send_req(ADD, VEC32, word_t'(i), $urandom, '0);
    end
    end_burst();
    repeat (20) @(negedge clk);
    checks++;
    assert (rsp_total - base <= `SIMD_OUT_CREDITS) else begin
      $display("back_pressure: %0d results left the DUT with only %0d credits",
               rsp_total - base, `SIMD_OUT_CREDITS);
      test_errors++;
    end
    hold_credits = 1'b0;
    drain_and_check("back_pressure");
    finish_test("back_pressure");
  endtask

  task automatic test_up_credits();
    int base;
    // earlier credit pulses come a cycle after their pop and so before the results
    repeat (2) @(negedge clk);
    base = credits_back;
    for (int i = 0; i < BURST_REQS; i++) begin
      send_req(XOR, VEC8, $urandom, $urandom, '0);
    end
    end_burst();
    drain_and_check("upstream_credit");
    repeat (4) @(negedge clk);
    checks++;
    assert (credits_back - base == BURST_REQS) else begin
      $display("upstream_credit: %0d credit pulses after a burst of %0d requests",
               credits_back - base, BURST_REQS);
      test_errors++;
    end
    checks++;
    assert (credits_back == sent_total) else begin
      $display("upstream_credit: %0d credit pulses in all for %0d requests sent",
               credits_back, sent_total);
      test_errors++;
    end
    finish_test("upstream_credit");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hd503_3493));
    req_valid    = 1'b0;
    req          = '0;
    rsp_credit   = 1'b0;
    hold_credits = 1'b0;
    modes        = '{VEC32, VEC16, VEC8};
    @(posedge rst_n);
    test_reset_state();
    test_lane_arith();
    test_compare();
    test_relu_mac();
    test_back_pressure();
    test_up_credits();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- simd_alu_top.f
+incdir+design
design/simd_lane_pkg.sv
design/simd_op_pkg.sv
design/credit_fifo.sv
design/flow_ctrl.sv
design/lane_arith_stage.sv
design/dot_mac_stage.sv
design/simd_alu_top.sv
sim/tb_clock_gen.sv
sim/simd_alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the SIMD ALU testbench with Verilator, run it and decide pass or fail from the log.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simd_alu_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f simd_alu_top.f \
  --top-module simd_alu_tb \
  -Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
  exit 1
fi

if grep -q "Test completed successfully" "${LOG_FILE}"; then
  exit 0
fi
echo "pass message not found in ${LOG_FILE}"
exit 1
